// File: lcd_subsystem.f
+incdir+sim
source/lcd_pkg.sv
source/lcd_init_seq.sv
source/lcd_write_cycle.sv
source/lcd_pin_driver.sv
source/lcd_subsystem.sv
sim/lcd_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module lcd_tb \
	-f lcd_subsystem.f \
	-o lcd_sim \
	&& ./obj_dir/lcd_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }

exit 0

// File: sim/lcd_tb_tasks.svh
// busy rises one cycle after release and spans four pulses with their gaps
task automatic expect_init_sequence(input logic [CFG_BITS-1:0] cfg);
	logic [7:0] exp_byte [4];
	int         gap_after [3];
	int         exp_rise;
	exp_byte[0]  = {4'b0011, cfg[6:5], 2'b00};	// function set
	exp_byte[1]  = {5'b00001, cfg[4:2]};
	exp_byte[2]  = 8'b00000001;	// clear
	exp_byte[3]  = {6'b000001, cfg[1:0]};
	gap_after[0] = T_CMD_PULSE + T_WAIT_FSET;
	gap_after[1] = T_CMD_PULSE + T_WAIT_DISP;
	gap_after[2] = T_CMD_PULSE + T_WAIT_CLEAR;
	exp_rise     = T_POWER_UP + 1;
	while (busy_width.size() == 0) @(posedge clk);
	if (busy_rise_cyc[0] != 1) log_mismatch("busy rise cycle", busy_rise_cyc[0], 1);
	if (busy_width[0] != INIT_LEN) log_mismatch("busy width", busy_width[0], INIT_LEN);
	if (e_width.size() != 4) begin
		note_failure($sformatf("init gave %0d e pulses instead of four", e_width.size()));
	end else begin
		for (int i = 0; i < 4; i++) begin
			if (e_rise_cyc[i] != exp_rise) log_mismatch("e rise cycle", e_rise_cyc[i], exp_rise);
			if (e_width[i] != T_CMD_PULSE) log_mismatch("e width", e_width[i], T_CMD_PULSE);
			if (cap_data[i] !== exp_byte[i]) log_mismatch("lcd_data", cap_data[i], exp_byte[i]);
			if (cap_rs[i] !== 1'b0) log_mismatch("rs", cap_rs[i], 0);
			if (cap_rw[i] !== 1'b0) log_mismatch("rw", cap_rw[i], 0);
			if (i < 3) exp_rise += gap_after[i];
		end
	end
endtask

// enable is high for exactly one sampling edge
task automatic send_word(input logic [BUS_BITS-1:0] word);
	@(posedge clk);
	lcd_bus    <= word;
	lcd_enable <= 1'b1;
	@(posedge clk);
	lcd_enable <= 1'b0;
endtask

task automatic check_write(input logic [BUS_BITS-1:0] word, input int np, input int nb);
	if (e_width.size() != np + 1) begin
		note_failure($sformatf("write gave %0d e pulses instead of one", e_width.size() - np));
	end else begin
		if (cap_rs[np] !== word[9]) log_mismatch("rs", cap_rs[np], word[9]);
		if (cap_rw[np] !== word[8]) log_mismatch("rw", cap_rw[np], word[8]);
		if (cap_data[np] !== word[7:0]) log_mismatch("lcd_data", cap_data[np], word[7:0]);
		if (e_width[np] != T_E_HIGH_END - T_E_SETUP)
			log_mismatch("e width", e_width[np], T_E_HIGH_END - T_E_SETUP);
		if (e_rise_cyc[np] - busy_rise_cyc[nb] != T_E_SETUP)
			log_mismatch("e setup", e_rise_cyc[np] - busy_rise_cyc[nb], T_E_SETUP);
	end
	if (busy_width[nb] != T_WRITE_CYCLE + 1)
		log_mismatch("busy width", busy_width[nb], T_WRITE_CYCLE + 1);
endtask

task automatic write_and_check(input logic [BUS_BITS-1:0] word);
	int np;
	int nb;
	np = e_width.size();
	nb = busy_width.size();
	send_word(word);
	while (busy_width.size() == nb) @(posedge clk);
	check_write(word, np, nb);
endtask

task automatic power_up_init();
	logic [31:0] r;
	r = lcg_next();
	apply_reset(r[31:25]);
	expect_init_sequence(r[31:25]);
endtask

task automatic single_write();
	logic [31:0] r;
	r = lcg_next();
	write_and_check(r[31:22]);
endtask

// a second enable mid-write is dropped and never queued
task automatic enable_while_busy();
	logic [31:0] r1;
	logic [31:0] r2;
	int          np;
	int          nb;
	r1 = lcg_next();
	r2 = lcg_next();
	np = e_width.size();
	nb = busy_width.size();
	send_word(r1[31:22]);
	repeat (5) @(posedge clk);
	lcd_bus    <= r2[31:22];
	lcd_enable <= 1'b1;
	repeat (3) @(posedge clk);
	lcd_enable <= 1'b0;
	while (busy_width.size() == nb) @(posedge clk);
	check_write(r1[31:22], np, nb);
	repeat (5) @(posedge clk);
	if (e_width.size() != np + 1 || busy !== 1'b0)
		note_failure("enable raised during a write started another write");
	write_and_check(r2[31:22]);
endtask

task automatic random_burst();
	logic [31:0] r;
	for (int i = 0; i < N_BURST; i++) begin
		r = lcg_next();
		write_and_check(r[31:22]);
	end
endtask

task automatic reset_mid_write();
	logic [31:0] r;
	logic [31:0] cfg_r;
	r     = lcg_next();
	cfg_r = lcg_next();
	send_word(r[31:22]);
	repeat (8) @(posedge clk);	// inside the enable pulse
	apply_reset(cfg_r[31:25]);
	expect_init_sequence(cfg_r[31:25]);
endtask

// File: sim/lcd_tb.sv
`timescale 1ns/100ps

module lcd_tb import lcd_pkg::*; ();

	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 8;
	localparam logic [31:0] LCG_SEED     = 32'haa8c65d4;
	localparam int          N_BURST      = 8;

	// full init length in cycles, power-up plus four command/gap pairs
	localparam int INIT_LEN = T_POWER_UP + 4 * T_CMD_PULSE +
		T_WAIT_FSET + T_WAIT_DISP + T_WAIT_CLEAR + T_WAIT_ENTRY;
	localparam int N_WRITES = N_BURST + 4;
	localparam int WATCHDOG_CYCLES = 2 * (INIT_LEN + RESET_CYCLES) +
		N_WRITES * 60 * CLK_PER_US + 500;

	logic                clk;
	logic                rst;
	logic [CFG_BITS-1:0] init_cfg;
	logic                lcd_enable;
	logic [BUS_BITS-1:0] lcd_bus;
	logic                e;
	logic                rs;
	logic                rw;
	logic [7:0]          lcd_data;
	logic                busy;

	// pin monitor state
	int         cyc;	// cycles since reset release
	logic       e_prev;
	logic       busy_prev;
	int         e_run;
	int         busy_run;
	int         e_rise_cyc[$];
	int         e_width[$];
	logic [7:0] cap_data[$];	// lcd_data at each e rise
	logic       cap_rs[$];
	logic       cap_rw[$];
	int         busy_rise_cyc[$];
	int         busy_width[$];

	int          value_errors;
	int          other_errors;
	logic [31:0] lcg_state;

	lcd_subsystem UUT (
		.clk        (clk),
		.rst        (rst),
		.init_cfg   (init_cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// pins are sampled mid-cycle, away from the registering edge
	always @(negedge clk) begin
		if (rst) begin
			cyc       = 0;
			e_prev    = 1'b0;
			busy_prev = 1'b0;
			e_run     = 0;
			busy_run  = 0;
		end else begin
			if (e && !e_prev) begin
				e_rise_cyc.push_back(cyc);
				cap_data.push_back(lcd_data);
				cap_rs.push_back(rs);
				cap_rw.push_back(rw);
			end
			if (e) begin
				e_run++;
			end else if (e_prev) begin
				e_width.push_back(e_run);
				e_run = 0;
			end
			if (busy && !busy_prev) begin
				busy_rise_cyc.push_back(cyc);
			end
			if (busy) begin
				busy_run++;
			end else if (busy_prev) begin
				busy_width.push_back(busy_run);
				busy_run = 0;
			end
			e_prev    = e;
			busy_prev = busy;
			cyc++;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic log_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
		value_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		other_errors++;
	endtask

	task automatic clear_monitor();
		e_rise_cyc.delete();
		e_width.delete();
		cap_data.delete();
		cap_rs.delete();
		cap_rw.delete();
		busy_rise_cyc.delete();
		busy_width.delete();
	endtask

	// holds rst for the reset length, checks the pins went idle
	task automatic apply_reset(input logic [CFG_BITS-1:0] cfg);
		@(posedge clk);
		rst        <= 1'b1;
		lcd_enable <= 1'b0;
		init_cfg   <= cfg;
		repeat (RESET_CYCLES) @(posedge clk);
		if (e !== 1'b0) log_mismatch("e", e, 0);
		if (rs !== 1'b0) log_mismatch("rs", rs, 0);
		if (rw !== 1'b0) log_mismatch("rw", rw, 0);
		if (lcd_data !== 8'h00) log_mismatch("lcd_data", lcd_data, 0);
		if (busy !== 1'b0) log_mismatch("busy", busy, 0);
		clear_monitor();
		rst <= 1'b0;
	endtask

	`include "lcd_tb_tasks.svh"

	initial begin
		lcg_state    = LCG_SEED;
		value_errors = 0;
		other_errors = 0;
		rst          = 1'b1;
		init_cfg     = '0;
		lcd_enable   = 1'b0;
		lcd_bus      = '0;

		power_up_init();
		single_write();
		enable_while_busy();
		random_burst();
		reset_mid_write();

		$display("checks done: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("checks done: %0d value errors, %0d other errors",
			value_errors, other_errors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: source/lcd_init_seq.sv
`timescale 1ns/100ps

module lcd_init_seq import lcd_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [CFG_BITS-1:0] init_cfg,
	output logic                init_e,
	output logic [7:0]          init_data,
	output logic                init_busy,
	output logic                init_done
);

	typedef enum logic [2:0] {
		PH_POWER,	// power-up wait
		PH_FSET,	// function set
		PH_DISP,	// display on/off control
		PH_CLEAR,	// display clear
		PH_ENTRY,	// entry mode set
		PH_DONE
	} phase_t;

	phase_t              phase;
	phase_t              phase_next;
	logic [CNT_BITS-1:0] cnt;
	logic [CNT_BITS-1:0] phase_last;	// final count of the current phase
	logic                cnt_wrap;
	logic                cmd_phase;
	logic [7:0]          cmd_byte;

	// each command phase is its pulse followed by its gap
	always_comb begin
		case (phase)
			PH_POWER: phase_last = CNT_BITS'(T_POWER_UP - 1);
			PH_FSET:  phase_last = CNT_BITS'(T_CMD_PULSE + T_WAIT_FSET - 1);
			PH_DISP:  phase_last = CNT_BITS'(T_CMD_PULSE + T_WAIT_DISP - 1);
			PH_CLEAR: phase_last = CNT_BITS'(T_CMD_PULSE + T_WAIT_CLEAR - 1);
			PH_ENTRY: phase_last = CNT_BITS'(T_CMD_PULSE + T_WAIT_ENTRY - 1);
			default:  phase_last = '0;
		endcase
	end

	always_comb begin
		case (phase)
			PH_POWER: phase_next = PH_FSET;
			PH_FSET:  phase_next = PH_DISP;
			PH_DISP:  phase_next = PH_CLEAR;
			PH_CLEAR: phase_next = PH_ENTRY;
			default:  phase_next = PH_DONE;
		endcase
	end

	// command bytes, prefix plus config field
	always_comb begin
		case (phase)
			PH_FSET:  cmd_byte = {CMD_FSET_PREFIX, init_cfg[6:5], 2'b00};
			PH_DISP:  cmd_byte = {CMD_DISP_PREFIX, init_cfg[4:2]};
			PH_CLEAR: cmd_byte = CMD_CLEAR;
			PH_ENTRY: cmd_byte = {CMD_ENTRY_PREFIX, init_cfg[1:0]};
			default:  cmd_byte = 8'h00;
		endcase
	end

	assign cnt_wrap  = (cnt == phase_last);
	assign cmd_phase = (phase != PH_POWER) && (phase != PH_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_POWER;
			cnt   <= '0;
		end else if (phase != PH_DONE) begin
			if (cnt_wrap) begin
				phase <= phase_next;
				cnt   <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// e high only in the leading part of a command phase
	assign init_e    = cmd_phase && (cnt < CNT_BITS'(T_CMD_PULSE));
	assign init_data = init_e ? cmd_byte : 8'h00;	// quiet bus in the gaps
	assign init_busy = (phase != PH_DONE);
	assign init_done = (phase == PH_DONE);

	// done is sticky until the next reset
	a_done_sticky: assert property (
		@(posedge clk) init_done && !rst |=> init_done
	);

	// no init strobe once the write path owns the pins
	a_no_e_after_done: assert property (
		@(posedge clk) disable iff (rst) init_done |-> !init_e
	);

endmodule

// File: source/lcd_pin_driver.sv
`timescale 1ns/100ps

module lcd_pin_driver (
	input  logic       clk,
	input  logic       rst,
	input  logic       init_done,
	input  logic       init_e,
	input  logic [7:0] init_data,
	input  logic       init_busy,
	input  logic       wr_e,
	input  logic       wr_rs,
	input  logic       wr_rw,
	input  logic [7:0] wr_data,
	input  logic       wr_busy,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	logic       sel_e;
	logic       sel_rs;
	logic       sel_rw;
	logic [7:0] sel_data;
	logic       sel_busy;
	logic       quiet;	// nothing going on at the selected source

	// init owns the pins until done, commands only so rs and rw stay low
	always_comb begin
		if (init_done) begin
			sel_e    = wr_e;
			sel_rs   = wr_rs;
			sel_rw   = wr_rw;
			sel_data = wr_data;
			sel_busy = wr_busy;
		end else begin
			sel_e    = init_e;
			sel_rs   = 1'b0;
			sel_rw   = 1'b0;
			sel_data = init_data;
			sel_busy = init_busy;
		end
	end

	assign quiet = !sel_e && !sel_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
			busy     <= 1'b0;
		end else begin
			e        <= sel_e;
			rs       <= quiet ? 1'b0 : sel_rs;
			rw       <= quiet ? 1'b0 : sel_rw;
			lcd_data <= quiet ? 8'h00 : sel_data;
			busy     <= init_busy | wr_busy;	// same cycle as the pins
		end
	end

	// the write path only starts once init has released the bus
	a_one_owner: assert property (
		@(posedge clk) disable iff (rst) !(init_busy && wr_busy)
	);

endmodule

// File: source/lcd_pkg.sv
package lcd_pkg;

	// time base, every delay below is in units of CLK_PER_US cycles
	localparam int CLK_PER_US = 1;	// one cycle per unit in simulation

	// power-up and init command timing
	localparam int T_POWER_UP   = 500 * CLK_PER_US;
	localparam int T_CMD_PULSE  = 10 * CLK_PER_US;	// e high per init command
	localparam int T_WAIT_FSET  = 50 * CLK_PER_US;
	localparam int T_WAIT_DISP  = 50 * CLK_PER_US;
	localparam int T_WAIT_CLEAR = 200 * CLK_PER_US;	// clear is the slow one
	localparam int T_WAIT_ENTRY = 100 * CLK_PER_US;

	// write cycle enable edges
	localparam int T_E_SETUP     = 1 * CLK_PER_US;	// rs/rw settle before e
	localparam int T_E_HIGH_END  = 14 * CLK_PER_US;
	localparam int T_E_LOW_END   = 27 * CLK_PER_US;
	localparam int T_WRITE_CYCLE = 50 * CLK_PER_US;	// minimum write length

	// a write never ends before the low half of the enable pulse completes
	localparam int T_WRITE_HOLD = (T_WRITE_CYCLE > T_E_LOW_END) ?
		T_WRITE_CYCLE : T_E_LOW_END;

	// largest count is the power-up wait
	localparam int CNT_BITS = $clog2(T_POWER_UP) + 1;

	// init command prefixes
	localparam logic [3:0] CMD_FSET_PREFIX  = 4'b0011;	// 8-bit bus, low 2 bits zero
	localparam logic [4:0] CMD_DISP_PREFIX  = 5'b00001;
	localparam logic [7:0] CMD_CLEAR        = 8'b00000001;
	localparam logic [5:0] CMD_ENTRY_PREFIX = 6'b000001;

	// widths
	localparam int CFG_BITS = 7;	// {fset[1:0], disp[2:0], entry[1:0]}
	localparam int BUS_BITS = 10;	// {rs, rw, data[7:0]}

endpackage

// File: source/lcd_subsystem.sv
`timescale 1ns/100ps

module lcd_subsystem import lcd_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [CFG_BITS-1:0] init_cfg,
	input  logic                lcd_enable,
	input  logic [BUS_BITS-1:0] lcd_bus,
	output logic                e,
	output logic                rs,
	output logic                rw,
	output logic [7:0]          lcd_data,
	output logic                busy
);

	// init sequencer side
	logic       init_e;
	logic [7:0] init_data;
	logic       init_busy;
	logic       init_done;

	// write cycle side
	logic       wr_e;
	logic       wr_rs;
	logic       wr_rw;
	logic [7:0] wr_data;
	logic       wr_busy;

	lcd_init_seq u_init_seq (
		.clk       (clk),
		.rst       (rst),
		.init_cfg  (init_cfg),
		.init_e    (init_e),
		.init_data (init_data),
		.init_busy (init_busy),
		.init_done (init_done)
	);

	lcd_write_cycle u_write_cycle (
		.clk        (clk),
		.rst        (rst),
		.init_done  (init_done),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.wr_e       (wr_e),
		.wr_rs      (wr_rs),
		.wr_rw      (wr_rw),
		.wr_data    (wr_data),
		.wr_busy    (wr_busy)
	);

	lcd_pin_driver u_pin_driver (
		.clk       (clk),
		.rst       (rst),
		.init_done (init_done),
		.init_e    (init_e),
		.init_data (init_data),
		.init_busy (init_busy),
		.wr_e      (wr_e),
		.wr_rs     (wr_rs),
		.wr_rw     (wr_rw),
		.wr_data   (wr_data),
		.wr_busy   (wr_busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data),
		.busy      (busy)
	);

endmodule

// File: source/lcd_write_cycle.sv
`timescale 1ns/100ps

module lcd_write_cycle import lcd_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                init_done,
	input  logic                lcd_enable,
	input  logic [BUS_BITS-1:0] lcd_bus,
	output logic                wr_e,
	output logic                wr_rs,
	output logic                wr_rw,
	output logic [7:0]          wr_data,
	output logic                wr_busy
);

	logic                active;	// write in progress
	logic [CNT_BITS-1:0] cnt;
	logic [BUS_BITS-1:0] word_q;	// latched bus word
	logic                accept;
	logic                hold_end;

	// enable is a plain level and anything seen while active is dropped
	assign accept   = init_done && !active && lcd_enable;
	assign hold_end = (cnt == CNT_BITS'(T_WRITE_HOLD));

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (accept) begin
			active <= 1'b1;
			cnt    <= '0;
		end else if (active) begin
			if (hold_end) begin
				active <= 1'b0;	// back to idle
				cnt    <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= lcd_bus;
		end
	end

	// e rises after the setup time and falls at the end of the high half
	// cnt rests at zero while idle so the window alone shapes e
	assign wr_e = (cnt >= CNT_BITS'(T_E_SETUP)) &&
		(cnt < CNT_BITS'(T_E_HIGH_END));

	assign wr_rs   = word_q[BUS_BITS-1];
	assign wr_rw   = word_q[BUS_BITS-2];
	assign wr_data = word_q[7:0];
	assign wr_busy = active;

	a_e_in_busy: assert property (
		@(posedge clk) disable iff (rst) wr_e |-> wr_busy
	);

	// at least one busy cycle of setup before e rises
	a_e_setup: assert property (
		@(posedge clk) disable iff (rst) $rose(wr_e) |-> $past(wr_busy)
	);

	// the word does not change under a running write
	a_word_stable: assert property (
		@(posedge clk) disable iff (rst) active ##1 active |-> $stable(word_q)
	);

endmodule
